// ==== include/lagd_settings.svh ====
// **************************************
// lagd settings
// sizes and widths of the annealer macro
// **************************************
`ifndef LAGD_SETTINGS_SVH
`define LAGD_SETTINGS_SVH

// spin array
`define LAGD_NUM_SPIN 16

// signed coupling and bias widths
`define LAGD_BITJ 4
`define LAGD_BITH 4

// unsigned bias scale
`define LAGD_SCALING_BIT 4

// rows per weight beat
`define LAGD_PARALLELISM 4

`define LAGD_ENERGY_BIT 32

// write/compute phase counter
`define LAGD_COUNTER_BIT 16

`define LAGD_FLIP_ADDR_BIT 6

// flops between analog array and sample register
`define LAGD_SYNC_DEPTH 2

`endif

// ==== rtl/lagd_pkg.sv ====
// **************************************
// lagd package
// spin, weight, energy and analog phase
// types shared by the annealer stages
// **************************************
`default_nettype none

`include "lagd_settings.svh"

package lagd_pkg;

    // bit set means spin +1, clear means spin -1
    typedef logic [`LAGD_NUM_SPIN-1:0] spin_t;

    // one coupling row per spin, PARALLELISM rows per beat
    typedef logic signed [`LAGD_BITJ-1:0] jval_t;
    typedef jval_t [`LAGD_NUM_SPIN-1:0] jrow_t;
    typedef jrow_t [`LAGD_PARALLELISM-1:0] weight_beat_t;

    typedef logic signed [`LAGD_BITH-1:0] hval_t;
    typedef hval_t [`LAGD_NUM_SPIN-1:0] hbias_t;

    typedef logic signed [`LAGD_ENERGY_BIT-1:0] energy_t;

    typedef logic [$clog2(`LAGD_NUM_SPIN / `LAGD_PARALLELISM)-1:0] beat_idx_t;

    // analog wrap sequencing
    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        COMPUTE,
        SYNC,
        HOLD
    } aw_phase_e;

endpackage

`default_nettype wire

// ==== rtl/flip_manager.sv ====
// **************************************
// flip manager
// holds the best spin vector and energy,
// builds candidates from flip patterns
// and accepts lower energy results
// **************************************
`default_nettype none

`include "lagd_settings.svh"

module flip_manager (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           config_valid_i,
    input  lagd_pkg::spin_t                config_spin_i,
    input  logic                           cmpt_en_i,
    input  logic                           en_comparison_i,
    input  logic                           flip_disable_i,
    input  logic                           flush_i,
    input  logic [`LAGD_FLIP_ADDR_BIT-1:0] icon_last_raddr_plus_one_i,
    output logic                           flip_ren_o,
    output logic [`LAGD_FLIP_ADDR_BIT-1:0] flip_raddr_o,
    input  lagd_pkg::spin_t                flip_rdata_i,
    output logic                           cand_valid_o,
    output lagd_pkg::spin_t                cand_spin_o,
    input  logic                           cand_ready_i,
    input  logic                           en_valid_i,
    output logic                           en_ready_o,
    input  lagd_pkg::energy_t              en_energy_i,
    input  lagd_pkg::spin_t                en_spin_i,
    output lagd_pkg::spin_t                best_spin_o,
    output lagd_pkg::energy_t              best_energy_o,
    output logic                           cmpt_idle_o
);
    import lagd_pkg::*;

    localparam energy_t ENERGY_MAX = {1'b0, {(`LAGD_ENERGY_BIT-1){1'b1}}};

    typedef enum logic [1:0] {
        FM_IDLE,
        FM_READ,
        FM_OFFER,
        FM_WAIT
    } fm_state_e;

    fm_state_e                      state_q;
    logic [`LAGD_FLIP_ADDR_BIT-1:0] raddr_q;
    logic                           at_limit;
    logic                           accept;

    assign at_limit = (raddr_q == icon_last_raddr_plus_one_i);

    // one pattern in flight, next read only once the previous energy is back
    assign flip_ren_o   = (state_q == FM_IDLE) && cmpt_en_i && !at_limit;
    assign flip_raddr_o = raddr_q;
    assign cand_valid_o = (state_q == FM_OFFER);
    assign en_ready_o   = (state_q == FM_WAIT);

    // strict compare keeps the older vector on a tie
    assign accept = en_valid_i && en_ready_o &&
                    (!en_comparison_i || (en_energy_i < best_energy_o));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q       <= FM_IDLE;
            raddr_q       <= '0;
            cmpt_idle_o   <= 1'b0;
            best_spin_o   <= '0;
            best_energy_o <= '0;
        end else begin
            case (state_q)
                FM_IDLE: begin
                    if (flip_ren_o) begin
                        raddr_q <= raddr_q + 1'b1;
                        state_q <= FM_READ;
                    end
                end
                FM_READ: state_q <= FM_OFFER;
                FM_OFFER: begin
                    if (cand_ready_i) begin
                        state_q <= FM_WAIT;
                    end
                end
                default: begin
                    if (en_valid_i) begin
                        state_q <= FM_IDLE;
                    end
                end
            endcase

            if (flush_i) begin
                raddr_q <= '0;
            end

            if (config_valid_i || flush_i) begin
                cmpt_idle_o <= 1'b0;
            end else if ((state_q == FM_IDLE) && cmpt_en_i && at_limit) begin
                cmpt_idle_o <= 1'b1;
            end

            if (config_valid_i) begin
                best_spin_o   <= config_spin_i;
                best_energy_o <= ENERGY_MAX;
            end else if (accept) begin
                best_spin_o   <= en_spin_i;
                best_energy_o <= en_energy_i;
            end
        end
    end

    // flip data arrives the cycle after the read strobe
    always_ff @(posedge clk_i) begin
        if (state_q == FM_READ) begin
            cand_spin_o <= flip_disable_i ? best_spin_o : (best_spin_o ^ flip_rdata_i);
        end
    end

    cand_hold_a : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        cand_valid_o && !cand_ready_i |=> cand_valid_o && $stable(cand_spin_o)
    );

endmodule

`default_nettype wire

// ==== rtl/analog_wrap.sv ====
// **************************************
// analog wrap
// writes a candidate into the analog spin
// array, runs it and synchronizes the
// spins that come back
// **************************************
`default_nettype none

`include "lagd_settings.svh"

module analog_wrap (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic [`LAGD_COUNTER_BIT-1:0] cycle_per_spin_write_i,
    input  logic [`LAGD_COUNTER_BIT-1:0] cycle_per_spin_compute_i,
    input  logic                         cand_valid_i,
    input  lagd_pkg::spin_t              cand_spin_i,
    output logic                         cand_ready_o,
    output lagd_pkg::spin_t              spin_wwl_o,
    output lagd_pkg::spin_t              spin_compute_en_o,
    input  lagd_pkg::spin_t              analog_spin_i,
    output logic                         smp_valid_o,
    output lagd_pkg::spin_t              smp_spin_o,
    input  logic                         smp_ready_i
);
    import lagd_pkg::*;

    localparam int SYNC_DEPTH = `LAGD_SYNC_DEPTH;

    aw_phase_e                    state_q;
    logic [`LAGD_COUNTER_BIT-1:0] cnt_q;
    logic [`LAGD_COUNTER_BIT-1:0] cnt_last;
    logic                         cnt_done;
    spin_t                        wwl_q;
    spin_t                        sync_q [SYNC_DEPTH];

    // last count of the current phase
    always_comb begin
        case (state_q)
            WRITE:   cnt_last = cycle_per_spin_write_i - 1'b1;
            COMPUTE: cnt_last = cycle_per_spin_compute_i - 1'b1;
            default: cnt_last = `LAGD_COUNTER_BIT'(SYNC_DEPTH - 1);
        endcase
    end

    assign cnt_done = (cnt_q == cnt_last);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE:    if (cand_valid_i) state_q <= WRITE;
                WRITE:   if (cnt_done) state_q <= COMPUTE;
                COMPUTE: if (cnt_done) state_q <= SYNC;
                SYNC:    if (cnt_done) state_q <= HOLD;
                default: if (smp_ready_i) state_q <= IDLE;
            endcase

            if ((state_q inside {WRITE, COMPUTE, SYNC}) && !cnt_done) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
            end
        end
    end

    // shift only while syncing so the sample holds in HOLD
    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && cand_valid_i) begin
            wwl_q <= cand_spin_i;
        end
        if (state_q == SYNC) begin
            sync_q[0] <= analog_spin_i;
            for (int k = 1; k < SYNC_DEPTH; k++) begin
                sync_q[k] <= sync_q[k-1];
            end
        end
    end

    assign cand_ready_o      = (state_q == IDLE);
    assign spin_wwl_o        = (state_q == WRITE) ? wwl_q : '0;
    assign spin_compute_en_o = (state_q == COMPUTE) ? '1 : '0;
    assign smp_valid_o       = (state_q == HOLD);
    assign smp_spin_o        = sync_q[SYNC_DEPTH-1];

    wwl_compute_excl_a : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !((|spin_wwl_o) && (|spin_compute_en_o))
    );

endmodule

`default_nettype wire

// ==== rtl/energy_monitor.sv ====
// **************************************
// energy monitor
// Ising energy of one sampled spin vector,
// accumulated over streamed weight beats
// **************************************
`default_nettype none

`include "lagd_settings.svh"

module energy_monitor (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         smp_valid_i,
    input  lagd_pkg::spin_t              smp_spin_i,
    output logic                         smp_ready_o,
    input  logic                         weight_valid_i,
    input  lagd_pkg::weight_beat_t       weight_i,
    input  lagd_pkg::hbias_t             hbias_i,
    input  logic [`LAGD_SCALING_BIT-1:0] hscaling_i,
    output lagd_pkg::beat_idx_t          weight_raddr_o,
    output logic                         weight_ready_o,
    output logic                         en_valid_o,
    output lagd_pkg::energy_t            en_energy_o,
    output lagd_pkg::spin_t              en_spin_o,
    input  logic                         en_ready_i
);
    import lagd_pkg::*;

    localparam int NUM_BEAT = `LAGD_NUM_SPIN / `LAGD_PARALLELISM;

    logic      busy_q;
    beat_idx_t beat_q;
    energy_t   acc_q;
    energy_t   beat_sum;
    energy_t   scale;
    spin_t     spin_q;
    logic      smp_fire;
    logic      beat_fire;

    assign smp_fire  = smp_valid_i && smp_ready_o;
    assign beat_fire = weight_valid_i && weight_ready_o;

    // hscaling is unsigned, zero extend before the signed multiply
    assign scale = energy_t'($signed({1'b0, hscaling_i}));

    // rows beat*P .. beat*P+P-1, s_i * (h term + sum_j J_ij * s_j)
    always_comb begin
        int      idx;
        energy_t row_sum;
        beat_sum = '0;
        for (int r = 0; r < `LAGD_PARALLELISM; r++) begin
            idx     = int'(beat_q) * `LAGD_PARALLELISM + r;
            row_sum = scale * energy_t'($signed(hbias_i[idx]));
            for (int j = 0; j < `LAGD_NUM_SPIN; j++) begin
                row_sum = spin_q[j] ? row_sum + energy_t'($signed(weight_i[r][j]))
                                    : row_sum - energy_t'($signed(weight_i[r][j]));
            end
            beat_sum = spin_q[idx] ? beat_sum + row_sum : beat_sum - row_sum;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q     <= 1'b0;
            beat_q     <= '0;
            en_valid_o <= 1'b0;
        end else begin
            if (smp_fire) begin
                busy_q <= 1'b1;
                beat_q <= '0;
            end else if (beat_fire) begin
                if (beat_q == beat_idx_t'(NUM_BEAT - 1)) begin
                    busy_q     <= 1'b0;
                    en_valid_o <= 1'b1;
                end
                beat_q <= beat_q + 1'b1;
            end

            if (en_valid_o && en_ready_i) begin
                en_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (smp_fire) begin
            spin_q <= smp_spin_i;
            acc_q  <= '0;
        end else if (beat_fire) begin
            acc_q <= acc_q + beat_sum;
        end
    end

    assign smp_ready_o    = !busy_q && !en_valid_o;
    assign weight_ready_o = busy_q;
    assign weight_raddr_o = beat_q;
    assign en_energy_o    = acc_q;
    assign en_spin_o      = spin_q;

    raddr_hold_a : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        weight_ready_o && !weight_valid_i |=> weight_ready_o && $stable(weight_raddr_o)
    );

endmodule

`default_nettype wire

// ==== rtl/digital_macro.sv ====
// **************************************
// digital macro
// annealing loop of flip manager, analog
// wrap and energy monitor
// **************************************
`default_nettype none

`include "lagd_settings.svh"

module digital_macro (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    // host control
    input  logic                           config_valid_i,
    input  lagd_pkg::spin_t                config_spin_i,
    input  logic                           cmpt_en_i,
    input  logic                           en_comparison_i,
    input  logic                           flip_disable_i,
    input  logic                           flush_i,
    input  logic [`LAGD_FLIP_ADDR_BIT-1:0] icon_last_raddr_plus_one_i,
    output logic                           cmpt_idle_o,
    output lagd_pkg::spin_t                best_spin_o,
    output lagd_pkg::energy_t              best_energy_o,
    input  logic [`LAGD_COUNTER_BIT-1:0]   cycle_per_spin_write_i,
    input  logic [`LAGD_COUNTER_BIT-1:0]   cycle_per_spin_compute_i,
    // flip memory
    output logic                           flip_ren_o,
    output logic [`LAGD_FLIP_ADDR_BIT-1:0] flip_raddr_o,
    input  lagd_pkg::spin_t                flip_rdata_i,
    // weight memory
    input  logic                           weight_valid_i,
    output logic                           weight_ready_o,
    output lagd_pkg::beat_idx_t            weight_raddr_o,
    input  lagd_pkg::weight_beat_t         weight_i,
    input  lagd_pkg::hbias_t               hbias_i,
    input  logic [`LAGD_SCALING_BIT-1:0]   hscaling_i,
    // analog spin array
    output lagd_pkg::spin_t                spin_wwl_o,
    output lagd_pkg::spin_t                spin_compute_en_o,
    input  lagd_pkg::spin_t                analog_spin_i
);
    import lagd_pkg::*;

    logic    cand_valid;
    logic    cand_ready;
    spin_t   cand_spin;
    logic    smp_valid;
    logic    smp_ready;
    spin_t   smp_spin;
    logic    en_valid;
    logic    en_ready;
    energy_t en_energy;
    spin_t   en_spin;

    flip_manager u_flip_manager (
        .clk_i                      (clk_i),
        .arst_n_i                   (arst_n_i),
        .config_valid_i             (config_valid_i),
        .config_spin_i              (config_spin_i),
        .cmpt_en_i                  (cmpt_en_i),
        .en_comparison_i            (en_comparison_i),
        .flip_disable_i             (flip_disable_i),
        .flush_i                    (flush_i),
        .icon_last_raddr_plus_one_i (icon_last_raddr_plus_one_i),
        .flip_ren_o                 (flip_ren_o),
        .flip_raddr_o               (flip_raddr_o),
        .flip_rdata_i               (flip_rdata_i),
        .cand_valid_o               (cand_valid),
        .cand_spin_o                (cand_spin),
        .cand_ready_i               (cand_ready),
        .en_valid_i                 (en_valid),
        .en_ready_o                 (en_ready),
        .en_energy_i                (en_energy),
        .en_spin_i                  (en_spin),
        .best_spin_o                (best_spin_o),
        .best_energy_o              (best_energy_o),
        .cmpt_idle_o                (cmpt_idle_o)
    );

    analog_wrap u_analog_wrap (
        .clk_i                    (clk_i),
        .arst_n_i                 (arst_n_i),
        .cycle_per_spin_write_i   (cycle_per_spin_write_i),
        .cycle_per_spin_compute_i (cycle_per_spin_compute_i),
        .cand_valid_i             (cand_valid),
        .cand_spin_i              (cand_spin),
        .cand_ready_o             (cand_ready),
        .spin_wwl_o               (spin_wwl_o),
        .spin_compute_en_o        (spin_compute_en_o),
        .analog_spin_i            (analog_spin_i),
        .smp_valid_o              (smp_valid),
        .smp_spin_o               (smp_spin),
        .smp_ready_i              (smp_ready)
    );

    energy_monitor u_energy_monitor (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .smp_valid_i    (smp_valid),
        .smp_spin_i     (smp_spin),
        .smp_ready_o    (smp_ready),
        .weight_valid_i (weight_valid_i),
        .weight_i       (weight_i),
        .hbias_i        (hbias_i),
        .hscaling_i     (hscaling_i),
        .weight_raddr_o (weight_raddr_o),
        .weight_ready_o (weight_ready_o),
        .en_valid_o     (en_valid),
        .en_energy_o    (en_energy),
        .en_spin_o      (en_spin),
        .en_ready_i     (en_ready)
    );

endmodule

`default_nettype wire

// ==== tests/tb_digital_macro.sv ====
// **************************************
// digital macro testbench
// ideal analog array, weight and flip
// memories, greedy reference model
// **************************************
`default_nettype none

`include "lagd_settings.svh"

module tb_digital_macro;
    import lagd_pkg::*;

    localparam int N              = `LAGD_NUM_SPIN;
    localparam int P              = `LAGD_PARALLELISM;
    localparam int WRITE_CYCLES   = 5;
    localparam int COMPUTE_CYCLES = 7;
    localparam int HSCALE         = 3;
    localparam int LIGHT_DELAY    = 2;
    localparam int HEAVY_DELAY    = 12;
    localparam int GREEDY_ROUNDS  = 12;
    localparam int LAST_ROUNDS    = 10;
    localparam int DIS_ROUNDS     = 3;
    localparam int ROUND_BASE     = WRITE_CYCLES + COMPUTE_CYCLES + `LAGD_SYNC_DEPTH + 10;
    localparam int LIGHT_ROUND    = ROUND_BASE + 4 * (LIGHT_DELAY + 2);
    localparam int HEAVY_ROUND    = ROUND_BASE + 4 * (HEAVY_DELAY + 2);
    localparam int TIMEOUT        = 20 * (100 + (GREEDY_ROUNDS + LAST_ROUNDS + DIS_ROUNDS)
                                    * LIGHT_ROUND + GREEDY_ROUNDS * HEAVY_ROUND);

    logic                           clk_i;
    logic                           arst_n_i;
    logic                           config_valid_i;
    spin_t                          config_spin_i;
    logic                           cmpt_en_i;
    logic                           en_comparison_i;
    logic                           flip_disable_i;
    logic                           flush_i;
    logic [`LAGD_FLIP_ADDR_BIT-1:0] icon_last_raddr_plus_one_i;
    logic                           cmpt_idle_o;
    spin_t                          best_spin_o;
    energy_t                        best_energy_o;
    logic [`LAGD_COUNTER_BIT-1:0]   cycle_per_spin_write_i;
    logic [`LAGD_COUNTER_BIT-1:0]   cycle_per_spin_compute_i;
    logic                           flip_ren_o;
    logic [`LAGD_FLIP_ADDR_BIT-1:0] flip_raddr_o;
    spin_t                          flip_rdata_i;
    logic                           weight_valid_i;
    logic                           weight_ready_o;
    beat_idx_t                      weight_raddr_o;
    weight_beat_t                   weight_i;
    hbias_t                         hbias_i;
    logic [`LAGD_SCALING_BIT-1:0]   hscaling_i;
    spin_t                          spin_wwl_o;
    spin_t                          spin_compute_en_o;
    spin_t                          analog_spin_i;

    jval_t j_mem [N][N];
    spin_t flip_mem [2**`LAGD_FLIP_ADDR_BIT];
    int    errors;
    int    checks;
    int    max_delay;
    int    wait_cnt;
    int    wwl_run;
    int    cen_run;
    int    compute_rounds;
    logic  arr_held;
    string cur_test;

    digital_macro digital_macro_inst (.*);

    always #10 clk_i = ~clk_i;

    // energy rule with s as +1 or -1
    function automatic int ising_energy(spin_t s);
        int e;
        int field;
        e = 0;
        for (int i = 0; i < N; i++) begin
            field = HSCALE * int'(hbias_i[i]);
            for (int j = 0; j < N; j++) begin
                field = field + int'(j_mem[i][j]) * (s[j] ? 1 : -1);
            end
            e = e + (s[i] ? field : -field);
        end
        return e;
    endfunction

    function automatic weight_beat_t beat_rows(beat_idx_t idx);
        weight_beat_t b;
        for (int r = 0; r < P; r++) begin
            for (int j = 0; j < N; j++) begin
                b[r][j] = j_mem[int'(idx) * P + r][j];
            end
        end
        return b;
    endfunction

    // flip memory returns data one cycle after the read strobe
    always @(posedge clk_i) begin
        if (flip_ren_o) begin
            flip_rdata_i <= flip_mem[flip_raddr_o];
        end
    end

    // weight memory with a random delay before each beat
    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            weight_valid_i <= 1'b0;
            wait_cnt       <= 0;
        end else if (weight_valid_i && weight_ready_o) begin
            weight_valid_i <= 1'b0;
        end else if (weight_ready_o && !weight_valid_i) begin
            if (wait_cnt == 0) begin
                weight_valid_i <= 1'b1;
                weight_i       <= beat_rows(weight_raddr_o);
                wait_cnt       <= $urandom_range(0, max_delay);
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    // ideal analog array holds what was written once compute starts
    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            arr_held      <= 1'b0;
            analog_spin_i <= '0;
        end else if (|spin_compute_en_o) begin
            arr_held <= 1'b1;
        end else if (weight_ready_o) begin
            arr_held <= 1'b0;
        end else if (!arr_held) begin
            analog_spin_i <= spin_wwl_o;
        end
    end

    // phase lengths and write/compute exclusion
    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            wwl_run = 0;
            cen_run = 0;
        end else begin
            checks++;
            overlap_a : assert (!((|spin_wwl_o) && (|spin_compute_en_o))) else begin
                errors++;
                $display("%s: write lines and compute enable active together", cur_test);
            end
            if (|spin_wwl_o) begin
                wwl_run++;
            end else if (wwl_run != 0) begin
                checks++;
                write_len_a : assert (wwl_run == WRITE_CYCLES) else begin
                    errors++;
                    $display("Mismatch %s write_cycles expected %0d actual %0d",
                             cur_test, WRITE_CYCLES, wwl_run);
                end
                wwl_run = 0;
            end
            if (|spin_compute_en_o) begin
                cen_run++;
            end else if (cen_run != 0) begin
                checks++;
                compute_len_a : assert (cen_run == COMPUTE_CYCLES) else begin
                    errors++;
                    $display("Mismatch %s compute_cycles expected %0d actual %0d",
                             cur_test, COMPUTE_CYCLES, cen_run);
                end
                cen_run = 0;
                compute_rounds++;
            end
        end
    end

    task automatic check_reset_state();
        checks++;
        reset_state_a : assert (!flip_ren_o && !weight_ready_o && !(|spin_wwl_o) &&
                                !(|spin_compute_en_o) && !cmpt_idle_o &&
                                best_spin_o == '0 && best_energy_o == '0) else begin
            errors++;
            $display("outputs not cleared after reset");
        end
    endtask

    // greedy replay of the accept rule over the first flip patterns
    task automatic greedy_model(input spin_t cfg, input logic cmp, input int limit,
                                output spin_t best, output int best_e);
        spin_t cand;
        int    e;
        best   = cfg;
        best_e = 32'h7fff_ffff;
        for (int k = 0; k < limit; k++) begin
            cand = best ^ flip_mem[k];
            e    = ising_energy(cand);
            if (!cmp || e < best_e) begin
                best   = cand;
                best_e = e;
            end
        end
    endtask

    // one annealing run of the DUT up to the flip limit
    task automatic run_test(input string name, input spin_t cfg, input logic cmp,
                            input logic dis, input int limit, input int delay,
                            input spin_t exp_spin, input int exp_energy);
        int rounds_before;
        cur_test  = name;
        max_delay = delay;
        @(posedge clk_i);
        flush_i                    <= 1'b1;
        config_valid_i             <= 1'b1;
        config_spin_i              <= cfg;
        en_comparison_i            <= cmp;
        flip_disable_i             <= dis;
        icon_last_raddr_plus_one_i <= `LAGD_FLIP_ADDR_BIT'(limit);
        @(posedge clk_i);
        flush_i        <= 1'b0;
        config_valid_i <= 1'b0;
        cmpt_en_i      <= 1'b1;
        rounds_before  = compute_rounds;
        @(negedge clk_i);
        while (!cmpt_idle_o) begin
            @(negedge clk_i);
        end
        checks += 3;
        best_energy_a : assert (best_energy_o == energy_t'(exp_energy)) else begin
            errors++;
            $display("Mismatch %s best_energy expected %0d actual %0d",
                     name, exp_energy, best_energy_o);
        end
        best_spin_a : assert (best_spin_o == exp_spin) else begin
            errors++;
            $display("Mismatch %s best_spin expected %h actual %h",
                     name, exp_spin, best_spin_o);
        end
        rounds_a : assert (compute_rounds - rounds_before == limit) else begin
            errors++;
            $display("Mismatch %s rounds expected %0d actual %0d",
                     name, limit, compute_rounds - rounds_before);
        end
        @(posedge clk_i);
        cmpt_en_i <= 1'b0;
    endtask

    initial begin
        #(TIMEOUT);
        $display("watchdog expired at %0t, annealing run did not finish", $time);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        spin_t greedy_spin;
        spin_t last_spin;
        int    greedy_energy;
        int    last_energy;
        void'($urandom(47));
        errors                     = 0;
        checks                     = 0;
        compute_rounds             = 0;
        max_delay                  = LIGHT_DELAY;
        cur_test                   = "reset";
        clk_i                      = 1'b0;
        arst_n_i                   = 1'b0;
        config_valid_i             = 1'b0;
        config_spin_i              = '0;
        cmpt_en_i                  = 1'b0;
        en_comparison_i            = 1'b1;
        flip_disable_i             = 1'b0;
        flush_i                    = 1'b0;
        icon_last_raddr_plus_one_i = '0;
        cycle_per_spin_write_i     = `LAGD_COUNTER_BIT'(WRITE_CYCLES);
        cycle_per_spin_compute_i   = `LAGD_COUNTER_BIT'(COMPUTE_CYCLES);
        flip_rdata_i               = '0;
        weight_valid_i             = 1'b0;
        weight_i                   = '0;
        analog_spin_i              = '0;
        hscaling_i                 = `LAGD_SCALING_BIT'(HSCALE);
        for (int i = 0; i < N; i++) begin
            hbias_i[i] = hval_t'($urandom);
            for (int j = 0; j < N; j++) begin
                j_mem[i][j] = jval_t'($urandom);
            end
        end
        for (int a = 0; a < 2**`LAGD_FLIP_ADDR_BIT; a++) begin
            flip_mem[a] = spin_t'($urandom);
        end

        repeat (3) @(posedge clk_i);
        check_reset_state();
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        check_reset_state();

        greedy_model(16'h3a5c, 1'b1, GREEDY_ROUNDS, greedy_spin, greedy_energy);
        run_test("greedy", 16'h3a5c, 1'b1, 1'b0, GREEDY_ROUNDS, LIGHT_DELAY,
                 greedy_spin, greedy_energy);
        greedy_model(16'h5e21, 1'b0, LAST_ROUNDS, last_spin, last_energy);
        run_test("no_compare", 16'h5e21, 1'b0, 1'b0, LAST_ROUNDS, LIGHT_DELAY,
                 last_spin, last_energy);
        // best stays at the configured vector
        run_test("flip_disable", 16'hc3a1, 1'b1, 1'b1, DIS_ROUNDS, LIGHT_DELAY,
                 16'hc3a1, ising_energy(16'hc3a1));
        // same problem again with a slow weight memory
        run_test("backpressure", 16'h3a5c, 1'b1, 1'b0, GREEDY_ROUNDS, HEAVY_DELAY,
                 greedy_spin, greedy_energy);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== digital_macro.f ====
+incdir+include
rtl/lagd_pkg.sv
rtl/flip_manager.sv
rtl/analog_wrap.sv
rtl/energy_monitor.sv
rtl/digital_macro.sv
tests/tb_digital_macro.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the digital macro testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_digital_macro \
    -f digital_macro.f -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log \
    && ! grep -q ">>> FAIL" sim.log \
    || { echo "simulation failed"; exit 1; }

echo "simulation passed"
exit 0
